// File: rob_config.svh
/*
 * Size settings for the reorder buffer. Every package and module that needs
 * a width or a depth includes this header and reads the macros below.
 */
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

`default_nettype none

// Transaction ID space
`define ROB_NUM_IDS   4
`define ROB_ID_W      2

// Number of distinct destinations a request can target
`define ROB_DEST_W    2

// Buffer slots and the matching index width
`define ROB_DEPTH     8
`define ROB_IDX_W     3

// Outstanding transactions tracked per ID
`define ROB_MAX_TXNS  4

// Width of the response payload
`define ROB_DATA_W    8

`default_nettype wire

`endif

// File: rob_txn_pkg.sv
/*
 * Request-side types of the reorder buffer.
 * The status table and the sequencer import this package for IDs,
 * destinations, slot indices and the per-ID queue entry.
 */
`include "rob_config.svh"
`default_nettype none

package rob_txn_pkg;

  // Transaction ID carried by requests and responses
  typedef logic [`ROB_ID_W-1:0] id_t;

  // Destination that serves a request
  typedef logic [`ROB_DEST_W-1:0] dest_t;

  // Index of one slot in the reorder buffer
  typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

  // One entry of an ID queue in the status table
  // The flag says whether the transaction was tagged for reordering,
  // and the index names the slot reserved for its response
  typedef struct packed {
    logic     rob_req;
    rob_idx_t rob_idx;
  } status_entry_t;

endpackage

`default_nettype wire

// File: rob_rsp_pkg.sv
/*
 * Response-side types of the reorder buffer.
 * Holds the response word stored in the buffer slots and the release
 * state of the sequencer.
 */
`include "rob_config.svh"
`default_nettype none

package rob_rsp_pkg;

  // Payload of a single-beat response
  typedef logic [`ROB_DATA_W-1:0] payload_t;

  // Response as it enters and leaves the design
  typedef struct packed {
    rob_txn_pkg::id_t id;
    payload_t         data;
  } rsp_t;

  // In write the sequencer forwards or stores incoming responses,
  // in read it drains a stored response from the buffer
  typedef enum logic {
    ROB_WRITE,
    ROB_READ
  } rob_state_e;

endpackage

`default_nettype wire

// File: rob_status_table.sv
/*
 * Per-ID status table of the reorder buffer. Keeps one queue of status
 * entries per ID, decides whether a new request needs reordering and
 * exposes the queue heads for the response and peek lookups.
 */
`timescale 1ns/100ps
`include "rob_config.svh"
`default_nettype none

module rob_status_table (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Request side
  input  logic                  ax_push_i,
  input  rob_txn_pkg::id_t      ax_id_i,
  input  rob_txn_pkg::dest_t    ax_dest_i,
  input  rob_txn_pkg::rob_idx_t ax_idx_i,
  output logic                  ax_gnt_o,
  output logic                  ax_rob_req_o,
  // Response lookup and pop
  input  rob_txn_pkg::id_t      rsp_id_i,
  output logic                  rsp_rob_req_o,
  output rob_txn_pkg::rob_idx_t rsp_idx_o,
  // Peek lookup used to find releasable data
  input  rob_txn_pkg::id_t      peek_id_i,
  output logic                  peek_valid_o,
  output rob_txn_pkg::rob_idx_t peek_idx_o,
  input  logic                  pop_i
);

  import rob_txn_pkg::*;

  localparam int PTR_W = $clog2(`ROB_MAX_TXNS);
  localparam int CNT_W = $clog2(`ROB_MAX_TXNS + 1);

  // Queue storage holds no reset, the counters say what is valid
  status_entry_t                        queue_q [`ROB_NUM_IDS][`ROB_MAX_TXNS];
  logic [`ROB_NUM_IDS-1:0][PTR_W-1:0]   wr_ptr_q;
  logic [`ROB_NUM_IDS-1:0][PTR_W-1:0]   rd_ptr_q;
  logic [`ROB_NUM_IDS-1:0][CNT_W-1:0]   count_q;
  dest_t [`ROB_NUM_IDS-1:0]             prev_dest_q;
  logic [`ROB_NUM_IDS-1:0]              reorder_q;
  logic                                 push;
  logic [`ROB_NUM_IDS-1:0]              push_vec;
  logic [`ROB_NUM_IDS-1:0]              pop_vec;
  status_entry_t                        rsp_head;
  status_entry_t                        peek_head;

  //////////////////////////////////////////////////
  // Lookups and the reorder decision
  //////////////////////////////////////////////////

  // An ID is granted while its queue still has room
  assign ax_gnt_o = (count_q[ax_id_i] != CNT_W'(`ROB_MAX_TXNS));
  assign push     = ax_push_i && ax_gnt_o;

  assign rsp_head  = queue_q[rsp_id_i][rd_ptr_q[rsp_id_i]];
  assign peek_head = queue_q[peek_id_i][rd_ptr_q[peek_id_i]];

  // An empty queue never reports a tagged head
  assign rsp_rob_req_o = (count_q[rsp_id_i] != '0) && rsp_head.rob_req;
  assign rsp_idx_o     = rsp_head.rob_idx;
  assign peek_valid_o  = (count_q[peek_id_i] != '0) && peek_head.rob_req;
  assign peek_idx_o    = peek_head.rob_idx;

  always_comb begin
    if (!reorder_q[ax_id_i] && (count_q[ax_id_i] == '0)) begin
      // First outstanding request of this ID
      ax_rob_req_o = 1'b0;
    end else if (!reorder_q[ax_id_i] && (prev_dest_q[ax_id_i] == ax_dest_i)) begin
      // Same destination as before, so responses return in order anyway
      ax_rob_req_o = 1'b0;
    end else begin
      ax_rob_req_o = 1'b1;
    end
  end

  // One-hot push and pop per ID for the occupancy counters
  always_comb begin
    push_vec = '0;
    pop_vec  = '0;
    push_vec[ax_id_i] = push;
    pop_vec[rsp_id_i] = pop_i;
  end

  //////////////////////////////////////////////////
  // Queue state
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      prev_dest_q <= '0;
      reorder_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q[ax_id_i]    <= wr_ptr_q[ax_id_i] + 1'b1;
        prev_dest_q[ax_id_i] <= ax_dest_i;
        if (ax_rob_req_o) begin
          reorder_q[ax_id_i] <= 1'b1;
        end
      end
      if (pop_i) begin
        rd_ptr_q[rsp_id_i] <= rd_ptr_q[rsp_id_i] + 1'b1;
      end
      // The ID stops reordering once its last entry leaves,
      // unless a new request for it arrives in the same cycle
      if (pop_i && (count_q[rsp_id_i] == CNT_W'(1)) && !(push && (ax_id_i == rsp_id_i))) begin
        reorder_q[rsp_id_i] <= 1'b0;
      end
      for (int i = 0; i < `ROB_NUM_IDS; i++) begin
        if (push_vec[i] && !pop_vec[i]) begin
          count_q[i] <= count_q[i] + 1'b1;
        end else if (pop_vec[i] && !push_vec[i]) begin
          count_q[i] <= count_q[i] - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[ax_id_i][wr_ptr_q[ax_id_i]] <= '{rob_req: ax_rob_req_o, rob_idx: ax_idx_i};
    end
  end

endmodule

`default_nettype wire

// File: rob_buffer.sv
/*
 * Slot storage of the reorder buffer. Each slot holds one response with a
 * valid and an allocated flag. The free space and the next slot to hand out
 * come from a leading-zero count of the allocated flags.
 */
`timescale 1ns/100ps
`include "rob_config.svh"
`default_nettype none

module rob_buffer (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Store an out-of-order response
  input  logic                  wr_i,
  input  rob_txn_pkg::rob_idx_t wr_idx_i,
  input  rob_rsp_pkg::rsp_t     wr_data_i,
  // Release a stored response
  input  logic                  rel_i,
  input  rob_txn_pkg::rob_idx_t rel_idx_i,
  // Free a slot whose response was forwarded in order
  input  logic                  drop_alloc_i,
  input  rob_txn_pkg::rob_idx_t drop_idx_i,
  // Reserve the slot at next_idx_o
  input  logic                  alloc_i,
  input  rob_txn_pkg::rob_idx_t rd_idx_i,
  output rob_rsp_pkg::rsp_t     rd_data_o,
  output logic                  rd_valid_o,
  input  rob_txn_pkg::rob_idx_t peek_idx_i,
  output logic                  peek_valid_o,
  output logic [`ROB_IDX_W:0]   free_count_o,
  output rob_txn_pkg::rob_idx_t next_idx_o
);

  import rob_txn_pkg::*;
  import rob_rsp_pkg::*;

  localparam int CNT_W = `ROB_IDX_W + 1;

  rsp_t                  data_q [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] valid_q;
  logic [`ROB_DEPTH-1:0] alloc_q;

  assign rd_data_o    = data_q[rd_idx_i];
  assign rd_valid_o   = valid_q[rd_idx_i];
  assign peek_valid_o = valid_q[peek_idx_i];

  //////////////////////////////////////////////////
  // Free space
  //////////////////////////////////////////////////

  // Counts the zeros above the highest allocated slot
  // Slots are handed out upward from there, so holes below the top
  // allocation are not reused until the slots above them drain
  always_comb begin
    free_count_o = CNT_W'(`ROB_DEPTH);
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      if (alloc_q[i]) begin
        free_count_o = CNT_W'(`ROB_DEPTH - 1 - i);
      end
    end
  end

  // The first free slot sits just above the highest allocated one
  assign next_idx_o = rob_idx_t'(`ROB_DEPTH - int'(free_count_o));

  //////////////////////////////////////////////////
  // Flags and payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
      alloc_q <= '0;
    end else begin
      if (wr_i) begin
        valid_q[wr_idx_i] <= 1'b1;
      end
      // A released slot is both empty and free again
      if (rel_i) begin
        valid_q[rel_idx_i] <= 1'b0;
        alloc_q[rel_idx_i] <= 1'b0;
      end
      if (drop_alloc_i) begin
        alloc_q[drop_idx_i] <= 1'b0;
      end
      if (alloc_i) begin
        alloc_q[next_idx_o] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      data_q[wr_idx_i] <= wr_data_i;
    end
  end

endmodule

`default_nettype wire

// File: rob_sequencer.sv
/*
 * Control of the reorder buffer. Gates requests on the table grant and the
 * buffer space, and steers every response to be forwarded, stored or
 * released through a two-state write/read machine.
 */
`timescale 1ns/100ps
`include "rob_config.svh"
`default_nettype none

module rob_sequencer (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Request handshakes
  input  logic                  ax_valid_i,
  output logic                  ax_ready_o,
  output logic                  ax_valid_o,
  input  logic                  ax_ready_i,
  input  logic                  ax_rob_req_i,
  // Response handshakes
  input  logic                  rsp_valid_i,
  output logic                  rsp_ready_o,
  input  rob_rsp_pkg::rsp_t     rsp_i,
  input  logic                  rsp_rob_req_i,
  input  rob_txn_pkg::rob_idx_t rsp_rob_idx_i,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output rob_rsp_pkg::rsp_t     rsp_o,
  // Status table control
  output logic                  st_ax_push_o,
  input  logic                  st_ax_gnt_i,
  output rob_txn_pkg::id_t      st_rsp_id_o,
  input  logic                  st_rsp_rob_req_i,
  input  rob_txn_pkg::rob_idx_t st_rsp_idx_i,
  output rob_txn_pkg::id_t      st_peek_id_o,
  input  logic                  st_peek_valid_i,
  input  rob_txn_pkg::rob_idx_t st_peek_idx_i,
  output logic                  st_pop_o,
  // Buffer control
  output logic                  buf_wr_o,
  output logic                  buf_rel_o,
  output logic                  buf_drop_o,
  output logic                  buf_alloc_o,
  output rob_txn_pkg::rob_idx_t buf_rd_idx_o,
  input  rob_rsp_pkg::rsp_t     buf_rd_data_i,
  input  logic                  buf_rd_valid_i,
  input  logic                  buf_peek_valid_i,
  input  logic [`ROB_IDX_W:0]   buf_free_count_i
);

  import rob_txn_pkg::*;
  import rob_rsp_pkg::*;

  rob_state_e state_q;
  rob_state_e state_d;
  id_t        peek_id_q;
  rob_idx_t   rd_idx_q;
  logic       out_valid_q;
  logic       out_valid_d;

  //////////////////////////////////////////////////
  // Request path
  //////////////////////////////////////////////////

  // A tagged request also needs a free slot before it may leave
  assign ax_valid_o   = ax_valid_i && st_ax_gnt_i && (!ax_rob_req_i || (buf_free_count_i != '0));
  assign ax_ready_o   = ax_valid_o && ax_ready_i;
  assign st_ax_push_o = ax_ready_o;
  assign buf_alloc_o  = ax_ready_o && ax_rob_req_i;

  //////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////

  // In write the table looks up the incoming ID, in read the peeked one
  assign st_rsp_id_o  = (state_q == ROB_WRITE) ? rsp_i.id : peek_id_q;
  assign st_peek_id_o = peek_id_q;
  assign buf_rd_idx_o = rd_idx_q;
  assign rsp_o        = (state_q == ROB_READ) ? buf_rd_data_i : rsp_i;

  always_comb begin
    state_d     = state_q;
    out_valid_d = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_ready_o = rsp_ready_i;
    st_pop_o    = 1'b0;
    buf_wr_o    = 1'b0;
    buf_rel_o   = 1'b0;
    buf_drop_o  = 1'b0;
    unique case (state_q)
      ROB_READ: begin
        // No new response enters while stored data drains
        rsp_ready_o = 1'b0;
        if (st_peek_valid_i && buf_peek_valid_i) begin
          // The slot index was registered last cycle, so valid follows one cycle later
          out_valid_d = 1'b1;
          rsp_valid_o = out_valid_q && buf_rd_valid_i;
          if (rsp_valid_o && rsp_ready_i) begin
            buf_rel_o   = 1'b1;
            st_pop_o    = 1'b1;
            out_valid_d = 1'b0;
          end
        end else begin
          state_d = ROB_WRITE;
        end
      end
      ROB_WRITE: begin
        if (st_peek_valid_i && buf_peek_valid_i) begin
          // Head data is waiting, drain it before taking anything new
          state_d     = ROB_READ;
          rsp_ready_o = 1'b0;
        end else if (rsp_valid_i) begin
          if (!rsp_rob_req_i) begin
            // Untagged responses are always in order
            rsp_valid_o = 1'b1;
            st_pop_o    = rsp_ready_i;
          end else if (st_rsp_rob_req_i && (rsp_rob_idx_i == st_rsp_idx_i)) begin
            // Tagged but at the head of its ID, so the slot is never written
            rsp_valid_o = 1'b1;
            st_pop_o    = rsp_ready_i;
            buf_drop_o  = rsp_ready_i;
          end else begin
            // Early response goes into its reserved slot
            buf_wr_o    = 1'b1;
            rsp_ready_o = 1'b1;
          end
        end
      end
      default: begin
        state_d = ROB_WRITE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= ROB_READ;
      out_valid_q <= 1'b0;
      peek_id_q   <= '0;
      rd_idx_q    <= '0;
    end else begin
      state_q     <= state_d;
      out_valid_q <= out_valid_d;
      rd_idx_q    <= st_peek_idx_i;
      // Peek at whichever ID last handed in a response
      if (rsp_valid_i && rsp_ready_o) begin
        peek_id_q <= rsp_i.id;
      end
    end
  end

endmodule

`default_nettype wire

// File: rob_top.sv
/*
 * Top level of the reorder buffer. Connects the per-ID status table, the
 * slot buffer and the sequencer to the request and response handshakes.
 */
`timescale 1ns/100ps
`include "rob_config.svh"
`default_nettype none

module rob_top (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Request in
  input  logic                  ax_valid_i,
  output logic                  ax_ready_o,
  input  rob_txn_pkg::id_t      ax_id_i,
  input  rob_txn_pkg::dest_t    ax_dest_i,
  // Request out with its reorder tag
  output logic                  ax_valid_o,
  input  logic                  ax_ready_i,
  output logic                  ax_rob_req_o,
  output rob_txn_pkg::rob_idx_t ax_rob_idx_o,
  // Response in with the echoed tag
  input  logic                  rsp_valid_i,
  output logic                  rsp_ready_o,
  input  rob_rsp_pkg::rsp_t     rsp_i,
  input  logic                  rsp_rob_req_i,
  input  rob_txn_pkg::rob_idx_t rsp_rob_idx_i,
  // Response out in request order
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output rob_rsp_pkg::rsp_t     rsp_o
);

  import rob_txn_pkg::*;
  import rob_rsp_pkg::*;

  logic                st_ax_push;
  logic                st_ax_gnt;
  id_t                 st_rsp_id;
  logic                st_rsp_rob_req;
  rob_idx_t            st_rsp_idx;
  id_t                 st_peek_id;
  logic                st_peek_valid;
  rob_idx_t            st_peek_idx;
  logic                st_pop;
  logic                buf_wr;
  logic                buf_rel;
  logic                buf_drop;
  logic                buf_alloc;
  rob_idx_t            buf_rd_idx;
  rsp_t                buf_rd_data;
  logic                buf_rd_valid;
  logic                buf_peek_valid;
  logic [`ROB_IDX_W:0] buf_free_count;

  // The next free slot doubles as the outgoing tag
  rob_status_table rob_status_table_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .ax_push_i     (st_ax_push),
    .ax_id_i       (ax_id_i),
    .ax_dest_i     (ax_dest_i),
    .ax_idx_i      (ax_rob_idx_o),
    .ax_gnt_o      (st_ax_gnt),
    .ax_rob_req_o  (ax_rob_req_o),
    .rsp_id_i      (st_rsp_id),
    .rsp_rob_req_o (st_rsp_rob_req),
    .rsp_idx_o     (st_rsp_idx),
    .peek_id_i     (st_peek_id),
    .peek_valid_o  (st_peek_valid),
    .peek_idx_o    (st_peek_idx),
    .pop_i         (st_pop)
  );

  // Stores and drops address the slot echoed with the response
  rob_buffer rob_buffer_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .wr_i         (buf_wr),
    .wr_idx_i     (rsp_rob_idx_i),
    .wr_data_i    (rsp_i),
    .rel_i        (buf_rel),
    .rel_idx_i    (buf_rd_idx),
    .drop_alloc_i (buf_drop),
    .drop_idx_i   (rsp_rob_idx_i),
    .alloc_i      (buf_alloc),
    .rd_idx_i     (buf_rd_idx),
    .rd_data_o    (buf_rd_data),
    .rd_valid_o   (buf_rd_valid),
    .peek_idx_i   (st_peek_idx),
    .peek_valid_o (buf_peek_valid),
    .free_count_o (buf_free_count),
    .next_idx_o   (ax_rob_idx_o)
  );

  rob_sequencer rob_sequencer_inst (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .ax_valid_i       (ax_valid_i),
    .ax_ready_o       (ax_ready_o),
    .ax_valid_o       (ax_valid_o),
    .ax_ready_i       (ax_ready_i),
    .ax_rob_req_i     (ax_rob_req_o),
    .rsp_valid_i      (rsp_valid_i),
    .rsp_ready_o      (rsp_ready_o),
    .rsp_i            (rsp_i),
    .rsp_rob_req_i    (rsp_rob_req_i),
    .rsp_rob_idx_i    (rsp_rob_idx_i),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_ready_i      (rsp_ready_i),
    .rsp_o            (rsp_o),
    .st_ax_push_o     (st_ax_push),
    .st_ax_gnt_i      (st_ax_gnt),
    .st_rsp_id_o      (st_rsp_id),
    .st_rsp_rob_req_i (st_rsp_rob_req),
    .st_rsp_idx_i     (st_rsp_idx),
    .st_peek_id_o     (st_peek_id),
    .st_peek_valid_i  (st_peek_valid),
    .st_peek_idx_i    (st_peek_idx),
    .st_pop_o         (st_pop),
    .buf_wr_o         (buf_wr),
    .buf_rel_o        (buf_rel),
    .buf_drop_o       (buf_drop),
    .buf_alloc_o      (buf_alloc),
    .buf_rd_idx_o     (buf_rd_idx),
    .buf_rd_data_i    (buf_rd_data),
    .buf_rd_valid_i   (buf_rd_valid),
    .buf_peek_valid_i (buf_peek_valid),
    .buf_free_count_i (buf_free_count)
  );

endmodule

`default_nettype wire

// File: rob_props.sv
/*
 * Concurrent checks on the handshakes of the reorder buffer top level.
 * Bound into rob_top from the testbench.
 */
`timescale 1ns/100ps
`default_nettype none

module rob_props (
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  ax_ready_o,
  input logic                  ax_rob_req_o,
  input rob_txn_pkg::rob_idx_t ax_rob_idx_o,
  input logic                  rsp_valid_o,
  input logic                  rsp_ready_o,
  input logic                  rsp_ready_i,
  input rob_rsp_pkg::rsp_t     rsp_o
);

  // A slot handed to a tagged request is not offered again on the next cycle
  slot_advance_a : assert property (@(posedge clk_i) disable iff (rst_i)
    (ax_ready_o && ax_rob_req_o) |=> (ax_rob_idx_o != $past(ax_rob_idx_o)))
    else $error("tagged request slot offered twice in a row");

  // A stalled output keeps its valid and its data
  rsp_hold_a : assert property (@(posedge clk_i) disable iff (rst_i)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o)))
    else $error("stalled response changed or dropped");

  // Forwarded responses pass back-pressure straight through
  rsp_forward_a : assert property (@(posedge clk_i) disable iff (rst_i)
    (rsp_valid_o && rsp_ready_o) |-> rsp_ready_i)
    else $error("response forwarded while output was stalled");

  // Response side is idle right after a reset edge
  reset_idle_a : assert property (@(posedge clk_i)
    rst_i |=> (!rsp_valid_o && !rsp_ready_o))
    else $error("response handshake active after reset");

endmodule

`default_nettype wire

// File: rob_tb.sv
/*
 * Trace-driven testbench for the reorder buffer. Requests and response
 * returns come from rob_trace.txt, a target model echoes the recorded tags,
 * and a monitor checks the per-ID output order under random back-pressure.
 */
`timescale 1ns/100ps
`include "rob_config.svh"
`default_nettype none

module rob_tb;

  import rob_txn_pkg::*;
  import rob_rsp_pkg::*;

  localparam int MAX_TXNS   = 64;
  localparam int WAIT_LIMIT = 200;
  localparam int DRAIN_LIMIT = 1000;

  logic     clk_i;
  logic     rst_i;
  logic     ax_valid_i;
  logic     ax_ready_o;
  id_t      ax_id_i;
  dest_t    ax_dest_i;
  logic     ax_valid_o;
  logic     ax_ready_i;
  logic     ax_rob_req_o;
  rob_idx_t ax_rob_idx_o;
  logic     rsp_valid_i;
  logic     rsp_ready_o;
  rsp_t     rsp_i;
  logic     rsp_rob_req_i;
  rob_idx_t rsp_rob_idx_i;
  logic     rsp_valid_o;
  logic     rsp_ready_i;
  rsp_t     rsp_o;

  // Target model with one record per accepted request
  id_t      txn_id [MAX_TXNS];
  logic     txn_tag [MAX_TXNS];
  rob_idx_t txn_idx [MAX_TXNS];
  logic [7:0] txn_pay [MAX_TXNS];
  logic     pay_known [MAX_TXNS];

  // Expected output order per ID as transaction numbers
  int order_q [`ROB_NUM_IDS][MAX_TXNS];
  int head [`ROB_NUM_IDS];
  int tail [`ROB_NUM_IDS];

  int   num_txns = 0;
  int   returns_sent = 0;
  int   outputs_seen = 0;
  int   error_count = 0;
  int   check_count = 0;
  logic timed_out = 1'b0;
  logic bp_on = 1'b0;
  logic [31:0] lfsr;

  rob_top rob_top_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .ax_valid_i    (ax_valid_i),
    .ax_ready_o    (ax_ready_o),
    .ax_id_i       (ax_id_i),
    .ax_dest_i     (ax_dest_i),
    .ax_valid_o    (ax_valid_o),
    .ax_ready_i    (ax_ready_i),
    .ax_rob_req_o  (ax_rob_req_o),
    .ax_rob_idx_o  (ax_rob_idx_o),
    .rsp_valid_i   (rsp_valid_i),
    .rsp_ready_o   (rsp_ready_o),
    .rsp_i         (rsp_i),
    .rsp_rob_req_i (rsp_rob_req_i),
    .rsp_rob_idx_i (rsp_rob_idx_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_ready_i   (rsp_ready_i),
    .rsp_o         (rsp_o)
  );

  bind rob_top rob_props rob_props_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ax_ready_o   (ax_ready_o),
    .ax_rob_req_o (ax_rob_req_o),
    .ax_rob_idx_o (ax_rob_idx_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_o  (rsp_ready_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_o        (rsp_o)
  );

  //////////////////////////////////////////////////
  // Clock, back-pressure and helpers
  //////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR bit per cycle where a set bit stalls the output side
  initial begin
    rsp_ready_i = 1'b0;
    lfsr = 32'h3dbb;
    forever begin
      @(negedge clk_i);
      if (bp_on) begin
        lfsr = lfsr_step(lfsr);
        rsp_ready_i = !lfsr[0];
      end
    end
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    error_count++;
    timed_out = 1'b1;
    $display("ERROR: timed out while waiting for %s", what);
  endtask

  //////////////////////////////////////////////////
  // Stimulus tasks that start and end on a falling edge
  //////////////////////////////////////////////////

  task automatic send_request(input id_t id, input dest_t dest, input logic tag_exp);
    int waited;
    waited = 0;
    ax_valid_i = 1'b1;
    ax_id_i    = id;
    ax_dest_i  = dest;
    @(posedge clk_i);
    while (!ax_ready_o && waited < WAIT_LIMIT) begin
      waited++;
      @(posedge clk_i);
    end
    if (!ax_ready_o) begin
      report_timeout($sformatf("request %0d to be accepted", num_txns));
    end else begin
      compare_value($sformatf("txn %0d tag", num_txns), 32'(tag_exp), 32'(ax_rob_req_o));
      txn_id[num_txns]    = id;
      txn_tag[num_txns]   = ax_rob_req_o;
      txn_idx[num_txns]   = ax_rob_idx_o;
      pay_known[num_txns] = 1'b0;
      order_q[id][tail[id]] = num_txns;
      tail[id]++;
      num_txns++;
    end
    @(negedge clk_i);
    ax_valid_i = 1'b0;
  endtask

  // A request that needs a slot while none is free must stay blocked
  task automatic blocked_request(input id_t id, input dest_t dest, input logic tag_exp);
    ax_valid_i = 1'b1;
    ax_id_i    = id;
    ax_dest_i  = dest;
    repeat (8) begin
      @(posedge clk_i);
      compare_value("blocked tag", 32'(tag_exp), 32'(ax_rob_req_o));
      compare_value("blocked ax_valid_o", 32'd0, 32'(ax_valid_o));
      compare_value("blocked ax_ready_o", 32'd0, 32'(ax_ready_o));
    end
    @(negedge clk_i);
    ax_valid_i = 1'b0;
  endtask

  task automatic return_response(input int txn, input logic [7:0] payload);
    int waited;
    waited = 0;
    txn_pay[txn]   = payload;
    pay_known[txn] = 1'b1;
    rsp_valid_i    = 1'b1;
    rsp_i.id       = txn_id[txn];
    rsp_i.data     = payload;
    rsp_rob_req_i  = txn_tag[txn];
    rsp_rob_idx_i  = txn_idx[txn];
    @(posedge clk_i);
    while (!rsp_ready_o && waited < WAIT_LIMIT) begin
      waited++;
      @(posedge clk_i);
    end
    if (!rsp_ready_o) begin
      report_timeout($sformatf("return of transaction %0d", txn));
    end else begin
      returns_sent++;
    end
    @(negedge clk_i);
    rsp_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (outputs_seen != returns_sent && waited < DRAIN_LIMIT) begin
      waited++;
      @(negedge clk_i);
    end
    if (outputs_seen != returns_sent) begin
      report_timeout("returned responses to come out");
    end
  endtask

  //////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////

  task automatic check_output();
    int id;
    int txn;
    id = int'(rsp_o.id);
    outputs_seen++;
    if (head[id] == tail[id]) begin
      error_count++;
      $display("ERROR: response for ID %0d came out with nothing outstanding", id);
    end else begin
      txn = order_q[id][head[id]];
      head[id]++;
      if (!pay_known[txn]) begin
        error_count++;
        $display("ERROR: transaction %0d came out before it was returned", txn);
      end else begin
        compare_value($sformatf("txn %0d payload", txn), 32'(txn_pay[txn]),
                      32'(rsp_o.data));
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_i && rsp_valid_o && rsp_ready_i) begin
      check_output();
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int    fd;
    int    code;
    int    kind;
    int    a;
    int    b;
    int    c;
    string line;
    ax_valid_i    = 1'b0;
    ax_id_i       = '0;
    ax_dest_i     = '0;
    ax_ready_i    = 1'b1;
    rsp_valid_i   = 1'b0;
    rsp_i         = '0;
    rsp_rob_req_i = 1'b0;
    rsp_rob_idx_i = '0;
    for (int i = 0; i < `ROB_NUM_IDS; i++) begin
      head[i] = 0;
      tail[i] = 0;
    end
    rst_i = 1'b1;
    repeat (16) @(posedge clk_i);
    compare_value("reset ax_valid_o", 32'd0, 32'(ax_valid_o));
    compare_value("reset ax_ready_o", 32'd0, 32'(ax_ready_o));
    compare_value("reset rsp_valid_o", 32'd0, 32'(rsp_valid_o));
    compare_value("reset rsp_ready_o", 32'd0, 32'(rsp_ready_o));
    @(negedge clk_i);
    rst_i = 1'b0;
    bp_on = 1'b1;

    fd = $fopen("rob_trace.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("ERROR: could not open the trace file");
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        code = $fgets(line, fd);
        if (code == 0 || line.len() == 0 || line.getc(0) == "#") begin
          continue;
        end
        if ($sscanf(line, "%d %h %h %h", kind, a, b, c) != 4) begin
          continue;
        end
        case (kind)
          1: send_request(id_t'(a), dest_t'(b), c[0]);
          2: return_response(a, 8'(b));
          3: blocked_request(id_t'(a), dest_t'(b), c[0]);
          4: wait_drain();
          default: begin
            error_count++;
            $display("ERROR: unknown event kind %0d in the trace", kind);
          end
        endcase
      end
      $fclose(fd);
    end

    if (!timed_out) begin
      wait_drain();
    end
    // Every request must have produced exactly one response
    for (int i = 0; i < `ROB_NUM_IDS; i++) begin
      if (head[i] != tail[i]) begin
        error_count++;
        $display("ERROR: ID %0d still has %0d responses missing", i, tail[i] - head[i]);
      end
    end

    $display("checks=%0d errors=%0d requests=%0d responses=%0d",
             check_count, error_count, num_txns, outputs_seen);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rob_trace.txt
# kind 1 request: id dest expected_tag | kind 2 return: txn payload 0
# kind 3 blocked request: id dest expected_tag | kind 4 wait for outputs: 0 0 0
1 3 1 0
2 0 a5 0
1 1 0 0
1 1 1 1
2 2 22 0
2 1 11 0
4 0 0 0
1 0 0 0
1 0 1 1
1 0 2 1
1 1 0 0
1 1 1 1
1 1 2 1
1 1 3 1
1 2 0 0
1 2 1 1
1 2 2 1
1 2 3 1
3 0 3 1
2 d d3 0
2 c d2 0
2 b d1 0
2 a d0 0
4 0 0 0
1 0 3 1
2 9 b3 0
2 8 b2 0
2 7 b1 0
2 6 b0 0
2 e 0f 0
2 5 03 0
2 4 02 0
2 3 01 0
4 0 0 0
1 3 2 0
1 3 2 0
1 2 1 0
1 3 0 1
1 2 3 1
2 12 c3 0
2 13 e1 0
2 f c0 0
2 11 e0 0
2 10 c1 0

// File: all.f
+incdir+.
rob_txn_pkg.sv
rob_rsp_pkg.sv
rob_status_table.sv
rob_buffer.sv
rob_sequencer.sv
rob_top.sv
rob_props.sv
rob_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= rob_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
